// ==== dbus_subsys.f ====
dbus_pkg.sv
dbus_if.sv
dbus_decode.sv
dbus_dmem.sv
dbus_timer.sv
dbus_result.sv
dbus_subsys.sv
tb_dbus_subsys.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_dbus_subsys
FILELIST ?= dbus_subsys.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb_dbus_subsys.sv ====
`timescale 1ns/1ps

module tb_dbus_subsys import dbus_pkg::*; ;

    localparam int RND_LEN   = 16;
    localparam int EXTRA_TXN = 8;       // Directed timer and back-pressure accesses

    typedef struct packed {
        mem_op_e   op;
        bus_addr_t addr;
        bus_data_t wdata;
        logic      err;
    } txn_t;

    logic        clk;
    logic        arst_n_i;
    logic        req_i;
    mem_op_e     op_i;
    bus_addr_t   addr_i;
    bus_data_t   wdata_i;
    logic        ack_o;
    bus_data_t   rdata_o;
    logic        err_o;
    logic        timer_irq_o;

    txn_t        table_q [$];
    bus_data_t   ref_mem [DMEM_WORDS];
    bus_data_t   ref_cmp = '1;          // mtimecmp reset value
    logic [31:0] lfsr = 32'h1537;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 1000;
    int          issue_cycle;

    dbus_subsys u_dbus_subsys (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_equal(input bus_data_t got, input bus_data_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic bus_data_t rand_bits(input int n);
        bus_data_t v;
        logic      fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic txn_t make_txn(input mem_op_e op, input bus_addr_t addr,
                                      input bus_data_t wdata, input logic err);
        txn_t t;
        t.op    = op;
        t.addr  = addr;
        t.wdata = wdata;
        t.err   = err;
        return t;
    endfunction

    task automatic add_entry(input mem_op_e op, input bus_addr_t addr,
                             input bus_data_t wdata, input logic err);
        table_q.push_back(make_txn(op, addr, wdata, err));
    endtask

    // Reference model where device 0x02 with bit 2 set is mtimecmp
    function automatic bus_data_t model_txn(input txn_t t);
        bus_data_t word;
        int        off;
        logic      is_timer;
        off      = int'(t.addr[1:0]);
        is_timer = (t.addr[31:24] == 8'h02);
        if (t.err) return '0;           // Faulting access changes nothing
        word = is_timer ? ref_cmp : ref_mem[t.addr[9:2]];
        case (t.op)
            OP_SB:   word[8*off +: 8]  = t.wdata[7:0];
            OP_SH:   word[8*off +: 16] = t.wdata[15:0];
            OP_SW:   word = t.wdata;
            OP_LB:   return {{24{word[8*off+7]}}, word[8*off +: 8]};
            OP_LBU:  return {24'h0, word[8*off +: 8]};
            OP_LH:   return {{16{word[8*off+15]}}, word[8*off +: 16]};
            OP_LHU:  return {16'h0, word[8*off +: 16]};
            default: return word;
        endcase
        if (is_timer) ref_cmp = word;
        else ref_mem[t.addr[9:2]] = word;
        return '0;                      // Stores read back zero
    endfunction

    // One four-phase handshake with req_i kept high for hold extra cycles
    task automatic run_txn(input txn_t t, input int hold, output bus_data_t rd);
        int lat;
        lat = 0;
        @(posedge clk);
        req_i   <= 1'b1;
        op_i    <= t.op;
        addr_i  <= t.addr;
        wdata_i <= t.wdata;
        @(posedge clk);                 // Decode samples req_i here
        issue_cycle = cycles;
        @(negedge clk);
        while (!ack_o) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        check_equal(lat, 3, "ack_o latency in cycles");
        check_equal(32'(err_o), 32'(t.err), "err_o");
        rd = rdata_o;
        repeat (hold) begin
            @(negedge clk);
            check_equal(32'(ack_o), 1, "ack_o held under back-pressure");
        end
        @(posedge clk);
        req_i <= 1'b0;
        @(negedge clk);
        check_equal(32'(ack_o), 1, "ack_o one cycle after req_i drop");
        @(negedge clk);
        check_equal(32'(ack_o), 0, "ack_o low after handshake");
    endtask

    task automatic apply_entry(input txn_t t, input int hold);
        bus_data_t exp;
        bus_data_t rd;
        exp = model_txn(t);
        run_txn(t, hold, rd);
        check_equal(rd, exp, $sformatf("rdata_o for op %0d at %h", t.op, t.addr));
    endtask

    task automatic build_table();
        add_entry(OP_SW, 32'h0000_0000, 32'h1122_3344, 1'b0);
        add_entry(OP_SW, 32'h0000_0010, 32'hA5A5_5A5A, 1'b0);
        add_entry(OP_SW, 32'h0000_03FC, 32'hDEAD_BEEF, 1'b0);
        add_entry(OP_LW, 32'h0000_0000, '0, 1'b0);
        add_entry(OP_LW, 32'h0000_0010, '0, 1'b0);
        add_entry(OP_LW, 32'h0000_03FC, '0, 1'b0);
        add_entry(OP_LW, 32'h0000_0400, '0, 1'b0);   // Aliases onto word 0
        for (int o = 0; o < 4; o++) begin
            add_entry(OP_SB, 32'h20 + o, {24'hA5A5A5, 8'(8'hF1 - 8'h70 * o)}, 1'b0);
        end
        add_entry(OP_SH, 32'h0000_0024, 32'hFFFF_8765, 1'b0);
        add_entry(OP_SH, 32'h0000_0026, 32'h0000_7ABC, 1'b0);
        for (int o = 0; o < 4; o++) begin
            add_entry(OP_LB,  32'h20 + o, '0, 1'b0);
            add_entry(OP_LBU, 32'h20 + o, '0, 1'b0);
        end
        for (int o = 0; o < 4; o += 2) begin
            add_entry(OP_LH,  32'h20 + o, '0, 1'b0);
            add_entry(OP_LHU, 32'h20 + o, '0, 1'b0);
            add_entry(OP_LH,  32'h24 + o, '0, 1'b0);
            add_entry(OP_LHU, 32'h24 + o, '0, 1'b0);
        end
        add_entry(OP_LW, 32'h0000_0020, '0, 1'b0);
        add_entry(OP_LW, 32'h0000_0024, '0, 1'b0);
        // Unmapped and misaligned accesses then readback of the words they would hit
        add_entry(OP_LW, 32'h0100_0000, '0, 1'b1);
        add_entry(OP_SW, 32'h0300_0010, 32'h0BAD_0BAD, 1'b1);
        add_entry(OP_LB, 32'hFF00_0003, '0, 1'b1);
        add_entry(OP_SH, 32'h0000_0011, 32'h0000_BEEF, 1'b1);
        add_entry(OP_SW, 32'h0000_0012, 32'hFFFF_FFFF, 1'b1);
        add_entry(OP_LH, 32'h0000_0013, '0, 1'b1);
        add_entry(OP_LW, 32'h0000_0002, '0, 1'b1);
        add_entry(OP_LW, 32'h0200_0006, '0, 1'b1);
        add_entry(OP_LW, 32'h0000_0010, '0, 1'b0);
        add_entry(OP_LW, 32'h0000_0000, '0, 1'b0);
        add_entry(OP_SW, 32'h0200_0004, 32'h8765_4321, 1'b0);
        add_entry(OP_SB, 32'h0200_0005, 32'h0000_00FF, 1'b0);   // Partial merge
        add_entry(OP_LW, 32'h0200_0004, '0, 1'b0);
        add_entry(OP_LH, 32'h0200_0006, '0, 1'b0);
        add_entry(OP_SW, 32'h0200_0004, 32'hFFFF_FFFF, 1'b0);
    endtask

    initial begin
        bus_data_t  t1;
        bus_data_t  t2;
        bus_data_t  idx;
        int         c1;
        logic [2:0] opsel;
        logic [1:0] off;
        mem_op_e    op;
        arst_n_i = 1'b0;
        req_i    = 1'b0;
        op_i     = OP_LW;
        addr_i   = '0;
        wdata_i  = '0;
        build_table();
        cycle_limit = 40 * (table_q.size() + 2 * RND_LEN + EXTRA_TXN) + 100;
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;

        foreach (table_q[i]) apply_entry(table_q[i], 0);
        check_equal(32'(timer_irq_o), 0, "timer_irq_o with mtimecmp all ones");

        // mtime advances at least once per clock
        run_txn(make_txn(OP_LW, 32'h0200_0000, '0, 1'b0), 0, t1);
        c1 = issue_cycle;
        run_txn(make_txn(OP_LW, 32'h0200_0000, '0, 1'b0), 0, t2);
        check_equal(32'(t2 > t1), 1, "mtime increases");
        check_equal(32'((t2 - t1) >= 32'(issue_cycle - c1)), 1, "mtime step vs cycles");

        // Back-pressure
        apply_entry(make_txn(OP_SW, 32'h0000_0040, 32'hCAFE_F00D, 1'b0), 5);
        apply_entry(make_txn(OP_SB, 32'h0000_0041, 32'h0000_0077, 1'b0), 4);
        apply_entry(make_txn(OP_LW, 32'h0000_0040, '0, 1'b0), 0);

        for (int i = 0; i < RND_LEN; i++) begin
            idx = rand_bits(DMEM_IDX_W);
            apply_entry(make_txn(OP_SW, {idx[29:0], 2'b00}, rand_bits(32), 1'b0), 0);
            opsel = 3'(rand_bits(3) % 5);
            off   = 2'(rand_bits(2));
            op    = mem_op_e'(opsel);
            if (op == OP_LW) off = 2'b00;
            if (op == OP_LH || op == OP_LHU) off[0] = 1'b0;
            apply_entry(make_txn(op, {idx[29:0], off}, '0, 1'b0), 0);
        end

        apply_entry(make_txn(OP_SW, 32'h0200_0004, '0, 1'b0), 0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_equal(32'(timer_irq_o), 1, "timer_irq_o after mtimecmp cleared");
        apply_entry(make_txn(OP_LW, 32'h0200_0004, '0, 1'b0), 0);

        $display("Simulation finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_dbus_subsys

// ==== dbus_subsys.sv ====
`timescale 1ns/1ps

module dbus_subsys import dbus_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      req_i,
    input  mem_op_e   op_i,
    input  bus_addr_t addr_i,
    input  bus_data_t wdata_i,
    output logic      ack_o,
    output bus_data_t rdata_o,
    output logic      err_o,
    output logic      timer_irq_o
);

    dbus_if u_bus ();

    dbus_decode u_decode (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .op_i     (op_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .ack_o    (ack_o),
        .bus      (u_bus.dec)
    );

    dbus_dmem u_dmem (
        .clk (clk),
        .bus (u_bus.dmem_tgt)
    );

    dbus_timer u_timer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bus         (u_bus.timer_tgt),
        .timer_irq_o (timer_irq_o)
    );

    dbus_result u_result (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (u_bus.res),
        .rdata_o  (rdata_o),
        .err_o    (err_o)
    );

endmodule : dbus_subsys

// ==== dbus_result.sv ====
`timescale 1ns/1ps

module dbus_result import dbus_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    dbus_if.res       bus,
    output bus_data_t rdata_o,
    output logic      err_o
);

    logic               stb_q;
    logic [TGT_NUM-1:0] sel_q;
    logic               fault_q;
    mem_op_e            op_q;
    logic [1:0]         off_q;
    bus_data_t          word;
    bus_data_t          lane;
    bus_data_t          load_val;

    // Line up request fields with target read data
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stb_q   <= 1'b0;
            sel_q   <= '0;
            fault_q <= 1'b0;
        end else begin
            stb_q   <= bus.stb;
            sel_q   <= bus.sel;
            fault_q <= bus.fault;
        end
    end

    always_ff @(posedge clk) begin
        op_q  <= bus.op;
        off_q <= bus.addr[1:0];
    end

    always_comb begin
        if (sel_q[TGT_DMEM]) begin
            word = bus.rdata_dmem;
        end else if (sel_q[TGT_TIMER]) begin
            word = bus.rdata_timer;
        end else begin
            word = '0;
        end
    end

    assign lane = word >> {off_q, 3'b000};     // Addressed field to bit 0

    always_comb begin
        case (op_q)
            OP_LB:   load_val = {{24{lane[7]}}, lane[7:0]};
            OP_LBU:  load_val = {24'h0, lane[7:0]};
            OP_LH:   load_val = {{16{lane[15]}}, lane[15:0]};
            OP_LHU:  load_val = {16'h0, lane[15:0]};
            OP_LW:   load_val = word;
            default: load_val = '0;             // Stores return nothing
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.rsp_valid <= 1'b0;
            err_o         <= 1'b0;
        end else begin
            bus.rsp_valid <= stb_q;
            if (stb_q) begin
                err_o <= fault_q;
            end
        end
    end

    // Held until the next transaction
    always_ff @(posedge clk) begin
        if (stb_q) begin
            rdata_o <= fault_q ? '0 : load_val;
        end
    end

endmodule : dbus_result

// ==== dbus_timer.sv ====
`timescale 1ns/1ps

module dbus_timer import dbus_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    dbus_if.timer_tgt bus,
    output logic      timer_irq_o
);

    bus_data_t mtime_q;
    bus_data_t mtimecmp_q;
    logic      hit;
    logic      cmp_sel;

    assign hit     = bus.stb & bus.sel[TGT_TIMER];
    assign cmp_sel = bus.addr[TIMER_REG_BIT];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;              // No interrupt until programmed
            timer_irq_o <= 1'b0;
        end else begin
            mtime_q     <= mtime_q + 1'b1;  // Free running, read only
            timer_irq_o <= (mtime_q >= mtimecmp_q);
            if (hit && bus.we && cmp_sel) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (bus.be[b]) begin
                        mtimecmp_q[8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            bus.rdata_timer <= cmp_sel ? mtimecmp_q : mtime_q;
        end
    end

    // Stores to offset 0 must not disturb the count
    a_mtime_ro: assert property (@(posedge clk)
        (arst_n_i && $past(arst_n_i)) |-> (mtime_q == $past(mtime_q) + 1'b1));

endmodule : dbus_timer

// ==== dbus_dmem.sv ====
`timescale 1ns/1ps

module dbus_dmem import dbus_pkg::*; (
    input  logic     clk,
    dbus_if.dmem_tgt bus
);

    bus_data_t mem [DMEM_WORDS];
    dmem_idx_t idx;
    logic      hit;

    assign idx = bus.addr[DMEM_IDX_LOW +: DMEM_IDX_W];   // Upper offset bits alias
    assign hit = bus.stb & bus.sel[TGT_DMEM];

    // Lane writes
    always_ff @(posedge clk) begin
        if (hit && bus.we) begin
            for (int b = 0; b < BE_W; b++) begin
                if (bus.be[b]) begin
                    mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // Registered read, old data on a store
    always_ff @(posedge clk) begin
        if (hit) begin
            bus.rdata_dmem <= mem[idx];
        end
    end

endmodule : dbus_dmem

// ==== dbus_decode.sv ====
`timescale 1ns/1ps

module dbus_decode import dbus_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      req_i,
    input  mem_op_e   op_i,
    input  bus_addr_t addr_i,
    input  bus_data_t wdata_i,
    output logic      ack_o,
    dbus_if.dec       bus
);

    dec_state_e                        state_q;
    logic [DEV_SEL_HIGH-DEV_SEL_LOW:0] dev_sel;
    logic                              dmem_hit;
    logic                              timer_hit;
    logic                              misalign;
    logic                              fault_d;
    logic                              is_store;
    logic [TGT_NUM-1:0]                sel_d;
    bus_data_t                         wdata_d;
    byte_sel_t                         be_d;

    assign dev_sel   = addr_i[DEV_SEL_HIGH:DEV_SEL_LOW];
    assign dmem_hit  = (dev_sel == DMEM_MATCH);
    assign timer_hit = (dev_sel == TIMER_MATCH);
    assign is_store  = (op_i == OP_SB) || (op_i == OP_SH) || (op_i == OP_SW);

    always_comb begin
        case (op_i)
            OP_LH, OP_LHU, OP_SH: misalign = addr_i[0];
            OP_LW, OP_SW:         misalign = |addr_i[1:0];
            default:              misalign = 1'b0;     // Bytes never misalign
        endcase
    end

    assign fault_d = misalign | ~(dmem_hit | timer_hit);

    always_comb begin
        sel_d = '0;
        if (!fault_d) begin
            sel_d[TGT_DMEM]  = dmem_hit;
            sel_d[TGT_TIMER] = timer_hit;
        end
    end

    // Move store data onto its byte lanes
    always_comb begin
        wdata_d = '0;
        be_d    = '0;
        case (op_i)
            OP_SB: begin
                wdata_d = {24'h0, wdata_i[7:0]} << {addr_i[1:0], 3'b000};
                be_d    = 4'b0001 << addr_i[1:0];
            end
            OP_SH: begin
                wdata_d = addr_i[1] ? {wdata_i[15:0], 16'h0} : {16'h0, wdata_i[15:0]};
                be_d    = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            OP_SW: begin
                wdata_d = wdata_i;
                be_d    = 4'b1111;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= DEC_IDLE;
            bus.stb   <= 1'b0;
            bus.sel   <= '0;
            bus.fault <= 1'b0;
            bus.we    <= 1'b0;
        end else begin
            bus.stb <= 1'b0;
            case (state_q)
                DEC_IDLE: begin
                    if (req_i) begin
                        state_q   <= DEC_ISSUE;
                        bus.stb   <= 1'b1;
                        bus.sel   <= sel_d;
                        bus.fault <= fault_d;
                        bus.we    <= is_store;
                    end
                end
                DEC_ISSUE: state_q <= DEC_WAIT;
                DEC_WAIT:  if (bus.rsp_valid) state_q <= DEC_ACK;
                DEC_ACK:   if (!req_i) state_q <= DEC_IDLE;    // Requester closed phase 3
                default:   state_q <= DEC_IDLE;
            endcase
        end
    end

    // Request payload, held for the whole transaction
    always_ff @(posedge clk) begin
        if (state_q == DEC_IDLE && req_i) begin
            bus.addr  <= addr_i;
            bus.op    <= op_i;
            bus.wdata <= wdata_d;
            bus.be    <= be_d;
        end
    end

    assign ack_o = (state_q == DEC_ACK);

    a_sel_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(bus.sel));

    a_stb_in_issue: assert property (@(posedge clk) disable iff (!arst_n_i)
        bus.stb |-> (state_q == DEC_ISSUE));

endmodule : dbus_decode

// ==== dbus_if.sv ====
`timescale 1ns/1ps

interface dbus_if import dbus_pkg::*;;

    logic               stb;          // One cycle per transaction
    logic [TGT_NUM-1:0] sel;          // One-hot, zero on fault
    logic               fault;
    logic               we;
    bus_addr_t          addr;
    bus_data_t          wdata;        // Already lane aligned
    byte_sel_t          be;
    mem_op_e            op;

    bus_data_t          rdata_dmem;
    bus_data_t          rdata_timer;
    logic               rsp_valid;

    modport dec (
        output stb, sel, fault, we, addr, wdata, be, op,
        input  rsp_valid
    );

    modport dmem_tgt (
        input  stb, sel, we, addr, wdata, be,
        output rdata_dmem
    );

    modport timer_tgt (
        input  stb, sel, we, addr, wdata, be,
        output rdata_timer
    );

    modport res (
        input  stb, sel, fault, op, addr, rdata_dmem, rdata_timer,
        output rsp_valid
    );

endinterface : dbus_if

// ==== dbus_pkg.sv ====
package dbus_pkg;

    // Bus widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8;

    // Address map
    localparam int unsigned DEV_SEL_HIGH  = 31;
    localparam int unsigned DEV_SEL_LOW   = 24;
    localparam logic [7:0]  DMEM_MATCH    = 8'h00;
    localparam logic [7:0]  TIMER_MATCH   = 8'h02;
    localparam int unsigned TIMER_REG_BIT = 2;      // 0 mtime, 1 mtimecmp

    // Data memory geometry, higher offsets alias
    localparam int unsigned DMEM_WORDS   = 256;
    localparam int unsigned DMEM_IDX_W   = $clog2(DMEM_WORDS);
    localparam int unsigned DMEM_IDX_LOW = 2;

    // Target indices into the one-hot select
    localparam int unsigned TGT_NUM   = 2;
    localparam int unsigned TGT_DMEM  = 0;
    localparam int unsigned TGT_TIMER = 1;

    typedef logic [ADDR_W-1:0]     bus_addr_t;
    typedef logic [DATA_W-1:0]     bus_data_t;
    typedef logic [BE_W-1:0]       byte_sel_t;
    typedef logic [DMEM_IDX_W-1:0] dmem_idx_t;

    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LBU = 3'd1,
        OP_LH  = 3'd2,
        OP_LHU = 3'd3,
        OP_LW  = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_e;

    typedef enum logic [1:0] {
        DEC_IDLE  = 2'd0,
        DEC_ISSUE = 2'd1,   // Strobe cycle
        DEC_WAIT  = 2'd2,   // Waiting on result stage
        DEC_ACK   = 2'd3
    } dec_state_e;

endpackage : dbus_pkg
